// ==== list.f ====
hdl/panel_pkg.sv
hdl/cmd_apb_port.sv
hdl/cmd_decoder.sv
hdl/cmd_fill_panel.sv
hdl/fill_area_walker.sv
hdl/frame_buffer.sv
hdl/panel_ctrl_top.sv
tests/panel_ctrl_checker.sv
tests/panel_ctrl_tb.sv

// ==== tests/panel_ctrl_tb.sv ====
// Testbench for the LED panel controller.
// Sends APB fill commands with random colours and regions and checks the frame buffer against a model.
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_tb;
    import panel_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT = 4000;
    localparam logic [31:0] RAND_SEED = 32'h69eb_1061;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata;
    logic [APB_DATA_BITS-1:0] prdata;
    logic pready;
    logic pslverr;
    logic fill_done;

    logic [7:0] model [FB_BYTES];
    int done_count;

    panel_ctrl_top u_panel_ctrl_top (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .fill_done(fill_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(negedge clk) begin
        if (!reset && fill_done) begin
            done_count <= done_count + 1;
        end
    end

    always @(negedge clk) begin
        if (u_panel_ctrl_top.u_checker.assert_errors != 0) begin
            $display("a checker assertion failed");
            $display("Test failures found");
            $fatal(1, "assertion failure in the checker");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("Test failures found");
        $fatal(1, "timeout");
    endtask

    task automatic apb_transfer(input logic write, input logic [APB_ADDR_BITS-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > WAIT_LIMIT) begin
                stop_on_timeout("pready");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk); // the transfer completes on this edge.
        #DRIVE_DELAY;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_cmd(input int value);
        logic [31:0] rdata;
        logic err;
        apb_transfer(1'b1, ADDR_CMD, {24'h0, 8'(value)}, rdata, err);
        check_value("pslverr", {31'h0, err}, 32'h0);
    endtask

    // pixels are clipped to the panel and the first colour byte lands at k of 0.
    function automatic void model_fill(input int x1, input int y1, input int w, input int h,
                                       input logic [15:0] color);
        int x_stop;
        int y_stop;
        x_stop = (x1 + w > PANEL_WIDTH) ? PANEL_WIDTH : x1 + w;
        y_stop = (y1 + h > PANEL_HEIGHT) ? PANEL_HEIGHT : y1 + h;
        for (int r = y1; r < y_stop; r++) begin
            for (int c = x1; c < x_stop; c++) begin
                model[(r * PANEL_WIDTH + c) * BYTES_PER_PIXEL] = color[15:8];
                model[(r * PANEL_WIDTH + c) * BYTES_PER_PIXEL + 1] = color[7:0];
            end
        end
    endfunction

    task automatic send_fill_panel(input logic [15:0] color);
        write_cmd(OP_FILL_PANEL);
        write_cmd(color[15:8]);
        write_cmd(color[7:0]);
        model_fill(0, 0, PANEL_WIDTH, PANEL_HEIGHT, color);
    endtask

    task automatic send_fill_area(input int x1, input int y1, input int w, input int h,
                                  input logic [15:0] color);
        write_cmd(OP_FILL_AREA);
        write_cmd(x1);
        write_cmd(y1);
        write_cmd(w);
        write_cmd(h);
        write_cmd(color[15:8]);
        write_cmd(color[7:0]);
        model_fill(x1, y1, w, h, color);
    endtask

    task automatic wait_fills(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_timeout("fill_done");
            end
            @(negedge clk);
        end
    endtask

    task automatic check_frame();
        logic [31:0] rdata;
        logic err;
        for (int n = 0; n < FB_BYTES; n++) begin
            apb_transfer(1'b0, ADDR_FB_BASE + 12'(4 * n), 32'h0, rdata, err);
            check_value("pslverr", {31'h0, err}, 32'h0);
            check_value($sformatf("fb[%0d]", n), rdata, {24'h0, model[n]});
        end
    endtask

    task automatic random_area();
        int base;
        base = done_count;
        send_fill_area($urandom_range(0, 19), $urandom_range(0, 9), $urandom_range(1, 12),
                       $urandom_range(1, 6), 16'($urandom));
        wait_fills(base + 1);
    endtask

    initial begin
        logic [31:0] rdata;
        logic err;
        logic [7:0] junk;
        int base;
        void'($urandom(RAND_SEED));
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        done_count = 0;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        apb_transfer(1'b0, ADDR_STATUS, 32'h0, rdata, err);
        check_value("status", rdata, 32'h2); // idle and ready for data.
        apb_transfer(1'b1, 12'h008, 32'h5a, rdata, err);
        check_value("pslverr", {31'h0, err}, 32'h1);
        apb_transfer(1'b0, 12'h008, 32'h0, rdata, err);
        check_value("pslverr", {31'h0, err}, 32'h1);
        apb_transfer(1'b0, ADDR_CMD, 32'h0, rdata, err);
        check_value("pslverr", {31'h0, err}, 32'h1);
        apb_transfer(1'b0, 12'h500, 32'h0, rdata, err);
        check_value("pslverr", {31'h0, err}, 32'h1);

        base = done_count;
        send_fill_panel(16'h0000);
        wait_fills(base + 1);
        send_fill_panel(16'($urandom));
        wait_fills(base + 2);
        check_frame();

        // one rectangle that crosses both panel edges, then random ones.
        base = done_count;
        send_fill_area(14, 6, 5, 4, 16'($urandom));
        wait_fills(base + 1);
        check_frame();
        repeat (3) begin
            random_area();
            check_frame();
        end

        base = done_count;
        send_fill_area(3, 2, 0, 4, 16'($urandom));
        wait_fills(base + 1);
        send_fill_area(3, 2, 5, 0, 16'($urandom));
        wait_fills(base + 2);
        check_frame();

        repeat (3) begin
            junk = 8'($urandom);
            if (junk == OP_FILL_PANEL || junk == OP_FILL_AREA) begin
                junk = junk + 8'h10;
            end
            write_cmd(junk);
        end
        random_area();
        check_frame();

        base = done_count;
        send_fill_panel(16'($urandom));
        apb_transfer(1'b0, ADDR_STATUS, 32'h0, rdata, err);
        check_value("status busy", {31'h0, rdata[STATUS_BUSY_BIT]}, 32'h1);
        repeat (3) begin
            send_fill_area($urandom_range(0, 19), $urandom_range(0, 9), $urandom_range(0, 12),
                           $urandom_range(0, 6), 16'($urandom));
        end
        wait_fills(base + 4);
        repeat (10) @(negedge clk);
        check_value("fill_done count", done_count, base + 4);
        check_frame();

        if (u_panel_ctrl_top.u_checker.assert_errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("a checker assertion failed");
            $display("Test failures found");
            $fatal(1, "assertion failure in the checker");
        end
    end

endmodule

`default_nettype wire

// ==== tests/panel_ctrl_checker.sv ====
// Concurrent checks on the panel controller top level.
// Covers the fill_done pulse, the APB ready after reset and the frame-buffer write address.
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_checker (
    input wire clk,
    input wire reset,
    input wire pready,
    input wire fill_done,
    input wire fb_wr_valid,
    input wire panel_pkg::fb_write_t fb_wr
);
    import panel_pkg::*;

    int assert_errors;

    initial assert_errors = 0;

    done_single: assert property (@(posedge clk) disable iff (reset) fill_done |=> !fill_done)
        else begin
            $error("fill_done stayed high for two cycles.");
            assert_errors++;
        end

    ready_after_reset: assert property (@(posedge clk) reset |=> !pready)
        else begin
            $error("pready high right after reset.");
            assert_errors++;
        end

    // a write must carry a known address and byte inside the buffer.
    write_in_range: assert property (@(posedge clk) disable iff (reset)
        fb_wr_valid |-> !$isunknown(fb_wr) && (fb_wr.addr < FB_BYTES))
        else begin
            $error("frame-buffer write address out of range.");
            assert_errors++;
        end

endmodule

bind panel_ctrl_top panel_ctrl_checker u_checker (
    .clk(clk), .reset(reset), .pready(pready), .fill_done(fill_done),
    .fb_wr_valid(fb_wr_valid), .fb_wr(fb_wr)
);

`default_nettype wire

// ==== hdl/panel_ctrl_top.sv ====
// LED panel controller top level.
// Chains the APB port, decoder, fill stage, walker and frame buffer.
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top (
    input wire clk,
    input wire reset,
    input wire psel,
    input wire penable,
    input wire pwrite,
    input wire [panel_pkg::APB_ADDR_BITS-1:0] paddr,
    input wire [panel_pkg::APB_DATA_BITS-1:0] pwdata,
    output logic [panel_pkg::APB_DATA_BITS-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic fill_done
);
    import panel_pkg::*;

    logic byte_valid;
    logic [7:0] byte_data;
    logic byte_ready;
    logic color_valid;
    logic [7:0] color_data;
    logic color_ready;
    fill_region_t region;
    logic walk_start;
    fill_req_t req;
    logic walk_done;
    logic busy;
    logic fb_wr_valid;
    fb_write_t fb_wr;
    logic [FB_ADDR_BITS-1:0] fb_rd_addr;
    logic [7:0] fb_rd_data;

    cmd_apb_port u_apb_port (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_ready(byte_ready),
        .busy(busy), .fb_rd_addr(fb_rd_addr), .fb_rd_data(fb_rd_data)
    );

    cmd_decoder u_decoder (
        .clk(clk), .reset(reset),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_ready(byte_ready),
        .color_valid(color_valid), .color_data(color_data), .region(region),
        .color_ready(color_ready)
    );

    cmd_fill_panel u_fill_panel (
        .clk(clk), .reset(reset),
        .color_valid(color_valid), .color_data(color_data), .region(region),
        .color_ready(color_ready), .walk_start(walk_start), .req(req),
        .walk_done(walk_done), .busy(busy), .fill_done(fill_done)
    );

    fill_area_walker u_walker (
        .clk(clk), .reset(reset),
        .walk_start(walk_start), .req(req),
        .fb_wr_valid(fb_wr_valid), .fb_wr(fb_wr), .walk_done(walk_done)
    );

    frame_buffer u_frame_buffer (
        .clk(clk),
        .fb_wr_valid(fb_wr_valid), .fb_wr(fb_wr),
        .fb_rd_addr(fb_rd_addr), .fb_rd_data(fb_rd_data)
    );

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
// Byte-wide frame memory.
// One write port from the walker and one registered read port for the host.
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input wire clk,
    input wire fb_wr_valid,
    input wire panel_pkg::fb_write_t fb_wr,
    input wire [panel_pkg::FB_ADDR_BITS-1:0] fb_rd_addr,
    output logic [7:0] fb_rd_data
);
    import panel_pkg::*;

    logic [7:0] mem [FB_BYTES];

    always_ff @(posedge clk) begin
        if (fb_wr_valid) begin
            mem[fb_wr.addr] <= fb_wr.data;
        end
    end

    // read data appears one cycle after the address.
    always_ff @(posedge clk) begin
        fb_rd_data <= mem[fb_rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/fill_area_walker.sv ====
// Rectangle walker.
// Clips the fill request to the panel and writes one frame-buffer byte per cycle.
`timescale 1ns/1ps
`default_nettype none

module fill_area_walker (
    input wire clk,
    input wire reset,
    input wire walk_start,
    input wire panel_pkg::fill_req_t req,
    output logic fb_wr_valid,
    output panel_pkg::fb_write_t fb_wr,
    output logic walk_done
);
    import panel_pkg::*;

    logic [8:0] x_end;
    logic [8:0] y_end;
    logic [8:0] x_stop;
    logic [8:0] y_stop;
    logic empty;
    logic active;
    logic last_k;
    logic last_col;
    logic last_row;
    logic [PIXEL_SEL_BITS-1:0] k;
    logic [COL_BITS-1:0] col;
    logic [COL_BITS-1:0] col_first;
    logic [COL_BITS-1:0] col_last;
    logic [ROW_BITS-1:0] row;
    logic [ROW_BITS-1:0] row_last;
    logic [COLOR_BITS-1:0] color;

    assign x_end = {1'b0, req.region.x1} + {1'b0, req.region.width};
    assign y_end = {1'b0, req.region.y1} + {1'b0, req.region.height};
    assign x_stop = (x_end > 9'(PANEL_WIDTH)) ? 9'(PANEL_WIDTH) : x_end;
    assign y_stop = (y_end > 9'(PANEL_HEIGHT)) ? 9'(PANEL_HEIGHT) : y_end;
    assign empty = (req.region.x1 >= 8'(PANEL_WIDTH)) || (req.region.y1 >= 8'(PANEL_HEIGHT)) ||
                   (req.region.width == '0) || (req.region.height == '0);

    assign last_k = (k == PIXEL_SEL_BITS'(BYTES_PER_PIXEL - 1));
    assign last_col = (col == col_last);
    assign last_row = (row == row_last);

    assign fb_wr_valid = active;

    always_comb begin
        fb_wr.addr = FB_ADDR_BITS'((row * PANEL_WIDTH + col) * BYTES_PER_PIXEL + k);
        fb_wr.data = color[COLOR_BITS - 8 - 8 * k +: 8]; // k of 0 takes the top byte.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            walk_done <= 1'b0;
        end else begin
            walk_done <= 1'b0;
            if (walk_start) begin
                active <= !empty;
                walk_done <= empty; // nothing to write, so finish right away.
            end else if (active && last_k && last_col && last_row) begin
                active <= 1'b0;
                walk_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (walk_start) begin
            k <= '0;
            col <= COL_BITS'(req.region.x1);
            col_first <= COL_BITS'(req.region.x1);
            col_last <= COL_BITS'(x_stop - 9'd1);
            row <= ROW_BITS'(req.region.y1);
            row_last <= ROW_BITS'(y_stop - 9'd1);
            color <= req.color;
        end else if (active) begin
            k <= k + 1'b1;
            if (last_k) begin
                k <= '0;
                if (last_col) begin
                    col <= col_first;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cmd_fill_panel.sv ====
// Colour capture and fill launch stage.
// Gathers the colour bytes, starts the area walk and pulses fill_done when it has finished.
`timescale 1ns/1ps
`default_nettype none

module cmd_fill_panel (
    input wire clk,
    input wire reset,
    input wire color_valid,
    input wire [7:0] color_data,
    input wire panel_pkg::fill_region_t region,
    output logic color_ready,
    output logic walk_start,
    output panel_pkg::fill_req_t req,
    input wire walk_done,
    output logic busy,
    output logic fill_done
);
    import panel_pkg::*;

    fill_state_t state;
    logic [PIXEL_SEL_BITS-1:0] bytes_left;
    logic done_level;
    logic done_q;

    assign color_ready = (state == FILL_CAPTURE);
    assign walk_start = (state == FILL_START);
    assign busy = (state != FILL_CAPTURE);
    assign fill_done = done_level && !done_q; // rising edge of the done level.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FILL_CAPTURE;
            bytes_left <= PIXEL_SEL_BITS'(BYTES_PER_PIXEL - 1);
            done_level <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= done_level;
            case (state)
                FILL_CAPTURE: begin
                    if (color_valid) begin
                        if (bytes_left == '0) begin
                            bytes_left <= PIXEL_SEL_BITS'(BYTES_PER_PIXEL - 1);
                            state <= FILL_START;
                        end else begin
                            bytes_left <= bytes_left - 1'b1;
                        end
                    end
                end
                FILL_START: state <= FILL_RUNNING;
                FILL_RUNNING: begin
                    if (walk_done) begin
                        state <= FILL_PREDONE;
                    end
                end
                FILL_PREDONE: begin
                    done_level <= 1'b1;
                    state <= FILL_DONE;
                end
                FILL_DONE: begin
                    done_level <= 1'b0;
                    state <= FILL_CAPTURE;
                end
                default: state <= FILL_CAPTURE;
            endcase
        end
    end

    // colour fills from the top byte down as the count falls.
    always_ff @(posedge clk) begin
        if (color_valid && color_ready) begin
            req.color[{bytes_left, 3'b000} +: 8] <= color_data;
            req.region <= region;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cmd_decoder.sv ====
// Command decoder.
// Parses opcodes and FILL_AREA geometry, then passes the colour bytes on to the fill stage.
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
    input wire clk,
    input wire reset,
    input wire byte_valid,
    input wire [7:0] byte_data,
    output logic byte_ready,
    output logic color_valid,
    output logic [7:0] color_data,
    output panel_pkg::fill_region_t region,
    input wire color_ready
);
    import panel_pkg::*;

    decode_state_t state;
    logic [PIXEL_SEL_BITS-1:0] color_count;
    logic byte_fire;

    assign byte_ready = (state == DEC_COLOR) ? color_ready : 1'b1;
    assign color_valid = (state == DEC_COLOR) && byte_valid;
    assign color_data = byte_data;
    assign byte_fire = byte_valid && byte_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DEC_OPCODE;
            color_count <= '0;
        end else if (byte_fire) begin
            case (state)
                DEC_OPCODE: begin
                    color_count <= '0;
                    case (cmd_opcode_t'(byte_data))
                        OP_FILL_PANEL: state <= DEC_COLOR;
                        OP_FILL_AREA: state <= DEC_X1;
                        default: state <= DEC_OPCODE; // unknown bytes are dropped.
                    endcase
                end
                DEC_X1: state <= DEC_Y1;
                DEC_Y1: state <= DEC_WIDTH;
                DEC_WIDTH: state <= DEC_HEIGHT;
                DEC_HEIGHT: state <= DEC_COLOR;
                DEC_COLOR: begin
                    color_count <= color_count + 1'b1;
                    if (color_count == PIXEL_SEL_BITS'(BYTES_PER_PIXEL - 1)) begin
                        state <= DEC_OPCODE;
                    end
                end
                default: state <= DEC_OPCODE;
            endcase
        end
    end

    // the region only changes outside DEC_COLOR, so it is stable while colour bytes flow.
    always_ff @(posedge clk) begin
        if (byte_fire) begin
            case (state)
                DEC_OPCODE: begin
                    if (cmd_opcode_t'(byte_data) == OP_FILL_PANEL) begin
                        region <= '{x1: 8'd0, y1: 8'd0,
                                    width: 8'(PANEL_WIDTH), height: 8'(PANEL_HEIGHT)};
                    end
                end
                DEC_X1: region.x1 <= byte_data;
                DEC_Y1: region.y1 <= byte_data;
                DEC_WIDTH: region.width <= byte_data;
                DEC_HEIGHT: region.height <= byte_data;
                default: region <= region;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cmd_apb_port.sv ====
// APB slave of the panel controller.
// Feeds command bytes to the decoder and answers status and frame-buffer reads.
`timescale 1ns/1ps
`default_nettype none

module cmd_apb_port (
    input wire clk,
    input wire reset,
    input wire psel,
    input wire penable,
    input wire pwrite,
    input wire [panel_pkg::APB_ADDR_BITS-1:0] paddr,
    input wire [panel_pkg::APB_DATA_BITS-1:0] pwdata,
    output logic [panel_pkg::APB_DATA_BITS-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic byte_valid,
    output logic [7:0] byte_data,
    input wire byte_ready,
    input wire busy,
    output logic [panel_pkg::FB_ADDR_BITS-1:0] fb_rd_addr,
    input wire [7:0] fb_rd_data
);
    import panel_pkg::*;

    logic access;
    logic is_cmd;
    logic is_status;
    logic is_fb;
    logic [APB_ADDR_BITS-1:0] fb_offset;
    logic fb_wait;

    assign access = psel && penable;
    assign is_cmd = (paddr == ADDR_CMD);
    assign is_status = (paddr == ADDR_STATUS);

    // offsets from 0x400 upward lie past the last buffer byte.
    assign fb_offset = paddr - ADDR_FB_BASE;
    assign is_fb = (paddr >= ADDR_FB_BASE) &&
                   (fb_offset[APB_ADDR_BITS-1:FB_ADDR_BITS+2] == '0);
    assign fb_rd_addr = fb_offset[FB_ADDR_BITS+1:2];

    assign byte_valid = access && pwrite && is_cmd;
    assign byte_data = pwdata[7:0];

    always_comb begin
        pready = 1'b0;
        pslverr = 1'b0;
        prdata = '0;
        if (access) begin
            if (pwrite) begin
                if (is_cmd) begin
                    pready = byte_ready; // wait states until the decoder takes the byte.
                end else begin
                    pready = 1'b1;
                    pslverr = 1'b1;
                end
            end else if (is_status) begin
                pready = 1'b1;
                prdata[STATUS_BUSY_BIT] = busy;
                prdata[STATUS_READY_BIT] = byte_ready;
            end else if (is_fb) begin
                pready = fb_wait;
                prdata[7:0] = fb_rd_data;
            end else begin
                pready = 1'b1;
                pslverr = 1'b1;
            end
        end
    end

    // high in the second access cycle of a buffer read, once the memory output is valid.
    always_ff @(posedge clk) begin
        if (reset) begin
            fb_wait <= 1'b0;
        end else begin
            fb_wait <= access && !pwrite && is_fb && !fb_wait;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/panel_pkg.sv ====
// Panel controller shared definitions.
// Holds the panel geometry, the APB register map, the command encodings and the stage payloads.
`default_nettype none

package panel_pkg;

    localparam int PANEL_WIDTH = 16;
    localparam int PANEL_HEIGHT = 8;
    localparam int BYTES_PER_PIXEL = 2;
    localparam int FB_BYTES = PANEL_WIDTH * PANEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int FB_ADDR_BITS = $clog2(FB_BYTES);
    localparam int COLOR_BITS = BYTES_PER_PIXEL * 8;

    localparam int COL_BITS = $clog2(PANEL_WIDTH);
    localparam int ROW_BITS = $clog2(PANEL_HEIGHT);
    localparam int PIXEL_SEL_BITS = $clog2(BYTES_PER_PIXEL);

    localparam int APB_ADDR_BITS = 12;
    localparam int APB_DATA_BITS = 32;

    localparam logic [APB_ADDR_BITS-1:0] ADDR_CMD = 12'h000;
    localparam logic [APB_ADDR_BITS-1:0] ADDR_STATUS = 12'h004;
    localparam logic [APB_ADDR_BITS-1:0] ADDR_FB_BASE = 12'h100; // byte n sits at base + 4n.

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_READY_BIT = 1;

    typedef enum logic [7:0] {
        OP_FILL_PANEL = 8'h01,
        OP_FILL_AREA = 8'h02
    } cmd_opcode_t;

    typedef enum logic [2:0] {
        DEC_OPCODE,
        DEC_X1,
        DEC_Y1,
        DEC_WIDTH,
        DEC_HEIGHT,
        DEC_COLOR
    } decode_state_t;

    typedef enum logic [2:0] {
        FILL_CAPTURE,
        FILL_START,
        FILL_RUNNING,
        FILL_PREDONE,
        FILL_DONE
    } fill_state_t;

    typedef struct packed {
        logic [7:0] x1;
        logic [7:0] y1;
        logic [7:0] width;
        logic [7:0] height;
    } fill_region_t;

    typedef struct packed {
        fill_region_t region;
        logic [COLOR_BITS-1:0] color; // first byte received is the top byte.
    } fill_req_t;

    typedef struct packed {
        logic [FB_ADDR_BITS-1:0] addr;
        logic [7:0] data;
    } fb_write_t;

endpackage

`default_nettype wire
